//--- src.f
verilog/fc_cfg_pkg.sv
verilog/fc_types_pkg.sv
verilog/fc_ibuf.sv
verilog/fc_ctrl.sv
verilog/cim_tile.sv
verilog/fc_func.sv
verilog/fc_top.sv
dv/fc_checker.sv
dv/fc_monitor.sv
dv/fc_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fc_tb -f src.f -o fc_sim

./obj_dir/fc_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"

//--- dv/fc_tb.sv
`timescale 1ns/1ps

module fc_tb import fc_cfg_pkg::*, fc_types_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;  // Cycles per wait loop

    logic       clk;
    logic       rst;
    logic       in_valid;
    in_vec_t    in_data;
    logic       in_ready;
    logic       out_valid;
    out_vec_t   out_data;
    logic       out_ready;
    logic       w_we;
    w_row_t     w_row;
    logic       busy;
    logic       stall_mode;  // Random back-pressure on the output
    logic [2:0] test_id;
    int         tb_errors;
    int         sent;
    int         mon_errors;
    int         accepted;
    int         checked;
    int         total;

    fc_top u_fc_top (
        .clk         (clk),
        .rst         (rst),
        .i_in_valid  (in_valid),
        .i_in_data   (in_data),
        .o_in_ready  (in_ready),
        .o_out_valid (out_valid),
        .o_out_data  (out_data),
        .i_out_ready (out_ready),
        .i_w_we      (w_we),
        .i_w_row     (w_row),
        .o_busy      (busy)
    );

    fc_monitor u_monitor (
        .clk         (clk),
        .rst         (rst),
        .i_in_valid  (in_valid),
        .i_in_ready  (in_ready),
        .i_in_data   (in_data),
        .i_w_we      (w_we),
        .i_w_row     (w_row),
        .i_out_valid (out_valid),
        .i_out_ready (out_ready),
        .i_out_data  (out_data),
        .i_test_id   (test_id),
        .o_errors    (mon_errors),
        .o_accepted  (accepted),
        .o_checked   (checked)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            out_ready = ($urandom_range(0, 2) != 0);  // Ready two cycles in three
        end else begin
            out_ready = 1'b1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            tb_errors++;
            $display("CHECK FAILED reset %s: expected %0b, actual %0b", what, exp, act);
        end
    endtask

    task automatic load_row(input int r, input logic [OUT_NEURONS-1:0][W_BITS-1:0] w);
        w_we      = 1'b1;
        w_row.row = ROW_W'(r);
        w_row.w   = w;
        next_cycle();
        w_we = 1'b0;
    endtask

    task automatic load_random_weights();
        for (int r = 0; r < IN_NEURONS; r++) begin
            load_row(r, $urandom);
        end
    endtask

    task automatic load_fill_weights(input logic [W_BITS-1:0] val);
        for (int r = 0; r < IN_NEURONS; r++) begin
            load_row(r, {OUT_NEURONS{val}});
        end
    endtask

    function automatic in_vec_t random_vector();
        in_vec_t v;
        for (int i = 0; i < IN_NEURONS; i++) begin
            v.act[i] = DATA_SIZE'($urandom_range(0, 255));
        end
        return v;
    endfunction

    function automatic in_vec_t fill_vector(input logic [DATA_SIZE-1:0] val);
        in_vec_t v;
        for (int i = 0; i < IN_NEURONS; i++) begin
            v.act[i] = val;
        end
        return v;
    endfunction

    // Hold valid until the buffer takes the vector
    task automatic send_vector(input in_vec_t v);
        int   cnt;
        logic taken;
        cnt      = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_data  = v;
        while (!taken && cnt < WAIT_LIMIT) begin
            taken = in_ready;  // Transfer happens at the coming edge
            next_cycle();
            cnt++;
        end
        in_valid = 1'b0;
        if (taken) begin
            sent++;
        end else begin
            tb_errors++;
            $display("Timeout: input vector was not accepted within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic send_random(input int gap_max);
        send_vector(random_vector());
        repeat ($urandom_range(0, gap_max)) next_cycle();
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (!(accepted == checked && !busy && in_ready && !out_valid)
               && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (!(accepted == checked && !busy && in_ready && !out_valid)) begin
            tb_errors++;
            $display("Timeout: layer did not drain and return to idle within %0d cycles",
                     WAIT_LIMIT);
        end
    endtask

    initial begin
        void'($urandom(56));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b1;
        w_we       = 1'b0;
        w_row      = '0;
        stall_mode = 1'b0;
        test_id    = 3'd0;
        tb_errors  = 0;
        sent       = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_bit("o_out_valid", 1'b0, out_valid);
        check_bit("o_busy", 1'b0, busy);
        check_bit("o_in_ready", 1'b1, in_ready);

        test_id = 3'd1;
        load_random_weights();
        repeat (20) send_random(3);
        wait_idle();

        test_id = 3'd2;
        send_vector(fill_vector(8'd0));
        wait_idle();

        test_id = 3'd3;
        load_fill_weights(4'h7);  // Largest positive weight
        send_vector(fill_vector(8'd255));
        wait_idle();

        test_id = 3'd4;
        load_fill_weights(4'h8);  // Most negative weight
        send_vector(fill_vector(8'd255));
        send_random(0);
        wait_idle();

        test_id = 3'd5;
        load_random_weights();
        stall_mode = 1'b1;
        repeat (15) send_random(1);
        wait_idle();
        stall_mode = 1'b0;

        test_id = 3'd6;
        repeat (10) send_random(0);
        wait_idle();

        test_id = 3'd7;
        repeat (4) begin
            load_random_weights();
            send_random(0);
            wait_idle();
        end

        if (accepted != sent || checked != sent) begin
            tb_errors++;
            $display("Sent %0d vectors but %0d were accepted and %0d outputs checked",
                     sent, accepted, checked);
        end

        total = tb_errors + mon_errors + int'(u_fc_top.u_checker.fail_count);
        $display("Error counts: testbench %0d, monitor %0d, assertions %0d",
                 tb_errors, mon_errors, u_fc_top.u_checker.fail_count);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dv/fc_monitor.sv
`timescale 1ns/1ps

module fc_monitor import fc_cfg_pkg::*, fc_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_in_valid,
    input  logic       i_in_ready,
    input  in_vec_t    i_in_data,
    input  logic       i_w_we,
    input  w_row_t     i_w_row,
    input  logic       i_out_valid,
    input  logic       i_out_ready,
    input  out_vec_t   i_out_data,
    input  logic [2:0] i_test_id,   // Tags each accepted vector
    output int         o_errors,
    output int         o_accepted,
    output int         o_checked
);

    int         w_model [IN_NEURONS][OUT_NEURONS];  // Signed weight copy
    out_vec_t   exp_q [$];
    logic [2:0] id_q [$];
    int         errors   = 0;
    int         accepted = 0;
    int         checked  = 0;

    assign o_errors   = errors;
    assign o_accepted = accepted;
    assign o_checked  = checked;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "random";
            3'd2:    return "zero_input";
            3'd3:    return "saturate";
            3'd4:    return "negative_weights";
            3'd5:    return "stalls";
            3'd6:    return "back_to_back";
            3'd7:    return "weight_rewrite";
            default: return "reset";
        endcase
    endfunction

    // Dot product, ReLU, scale, clamp
    function automatic out_vec_t expected_output(input in_vec_t v);
        out_vec_t res;
        int       sum;
        for (int c = 0; c < OUT_NEURONS; c++) begin
            sum = 0;
            for (int r = 0; r < IN_NEURONS; r++) begin
                sum += w_model[r][c] * int'(v.act[r]);
            end
            if (sum < 0) sum = 0;
            sum = sum >>> OUT_SHIFT;
            if (sum > OUT_MAX) sum = OUT_MAX;
            res.val[c] = OUT_BITS'(sum);
        end
        return res;
    endfunction

    always @(posedge clk) begin
        out_vec_t   exp_vec;
        logic [2:0] exp_id;
        if (!rst) begin
            if (i_w_we) begin
                for (int c = 0; c < OUT_NEURONS; c++) begin
                    w_model[i_w_row.row][c] = int'($signed(i_w_row.w[c]));
                end
            end
            if (i_in_valid && i_in_ready) begin  // Input handshake
                exp_q.push_back(expected_output(i_in_data));
                id_q.push_back(i_test_id);
                accepted++;
            end
            if (i_out_valid && i_out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output vector %h arrived with no accepted input pending",
                             i_out_data);
                end else begin
                    exp_vec = exp_q.pop_front();
                    exp_id  = id_q.pop_front();
                    checked++;
                    if (i_out_data !== exp_vec) begin
                        errors++;
                        $display("CHECK FAILED %s: expected %h, actual %h",
                                 test_name(exp_id), exp_vec, i_out_data);
                    end
                end
            end
        end
    end

endmodule

//--- dv/fc_checker.sv
`timescale 1ns/1ps

module fc_checker import fc_types_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     i_in_ready,
    input logic     i_busy,
    input logic     i_out_valid,
    input logic     i_out_ready,
    input out_vec_t i_out_data,
    input logic     i_cim_we,
    input logic     i_cim_start
);

    int unsigned fail_count = 0;  // Assertion failures so far

    // Stalled output keeps valid and data
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
        else begin
            fail_count++;
            $error("Output valid dropped or data changed while the output was stalled");
        end

    // Row-driver writes and crossbar starts are separate FSM states
    a_we_start: assert property (@(posedge clk) disable iff (rst)
        !(i_cim_we && i_cim_start))
        else begin
            fail_count++;
            $error("Row-driver write and crossbar start were high in the same cycle");
        end

    a_ready_busy: assert property (@(posedge clk) disable iff (rst)
        i_busy |-> !i_in_ready)
        else begin
            fail_count++;
            $error("Input ready was high while the layer was busy");
        end

endmodule

bind fc_top fc_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .i_in_ready  (o_in_ready),
    .i_busy      (o_busy),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_data  (o_out_data),
    .i_cim_we    (cim_we),
    .i_cim_start (cim_start)
);

//--- verilog/fc_top.sv
`timescale 1ns/1ps

module fc_top import fc_cfg_pkg::*, fc_types_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_in_valid,
    input  in_vec_t  i_in_data,
    output logic     o_in_ready,
    output logic     o_out_valid,
    output out_vec_t o_out_data,
    input  logic     i_out_ready,
    input  logic     i_w_we,      // Only while idle
    input  w_row_t   i_w_row,
    output logic     o_busy
);

    logic              full;
    logic              cim_we;
    logic              cim_start;
    logic              cim_first;
    logic              cim_ready;
    logic [ADDR_W-1:0] addr;
    logic              shift_enable;
    logic              func_start;
    logic              func_ready;
    logic              done;
    plane_word_t       word;
    acc_vec_t          acc;

    fc_ibuf u_ibuf (
        .clk            (clk),
        .rst            (rst),
        .i_in_valid     (i_in_valid),
        .i_in_data      (i_in_data),
        .o_in_ready     (o_in_ready),
        .i_shift_enable (shift_enable),
        .i_done         (done),
        .i_addr         (addr),
        .o_full         (full),
        .o_word         (word)
    );

    fc_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_start        (full),
        .i_cim_ready    (cim_ready),
        .i_func_ready   (func_ready),
        .o_busy         (o_busy),
        .o_cim_we       (cim_we),
        .o_cim_start    (cim_start),
        .o_cim_first    (cim_first),
        .o_addr         (addr),
        .o_shift_enable (shift_enable),
        .o_func_start   (func_start),
        .o_done         (done)
    );

    cim_tile u_tile (
        .clk         (clk),
        .rst         (rst),
        .i_w_we      (i_w_we),
        .i_w_row     (i_w_row),
        .i_cim_we    (cim_we),
        .i_addr      (addr),
        .i_word      (word),
        .i_cim_start (cim_start),
        .i_cim_first (cim_first),
        .o_cim_ready (cim_ready),
        .o_acc       (acc)
    );

    fc_func u_func (
        .clk          (clk),
        .rst          (rst),
        .i_func_start (func_start),
        .i_acc        (acc),
        .o_func_ready (func_ready),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data),
        .i_out_ready  (i_out_ready)
    );

endmodule

//--- verilog/fc_func.sv
`timescale 1ns/1ps

module fc_func import fc_cfg_pkg::*, fc_types_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_func_start,
    input  acc_vec_t i_acc,
    output logic     o_func_ready,
    output logic     o_out_valid,
    output out_vec_t o_out_data,
    input  logic     i_out_ready
);

    out_vec_t         res;
    logic [ACC_W-1:0] shifted [OUT_NEURONS];
    logic             load;

    assign o_func_ready = !o_out_valid;  // Single entry output register
    assign load         = i_func_start && o_func_ready;

    // ReLU, scale down, clamp to the output range
    always_comb begin
        for (int c = 0; c < OUT_NEURONS; c++) begin
            shifted[c] = i_acc.acc[c] >> OUT_SHIFT;
            if (i_acc.acc[c][ACC_W-1]) begin
                res.val[c] = '0;  // Negative sum
            end else if (shifted[c] > ACC_W'(OUT_MAX)) begin
                res.val[c] = OUT_BITS'(OUT_MAX);
            end else begin
                res.val[c] = shifted[c][OUT_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_out_valid <= 1'b0;
        end else if (load) begin
            o_out_valid <= 1'b1;
        end else if (i_out_ready) begin
            o_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_out_data <= res;
        end
    end

endmodule

//--- verilog/cim_tile.sv
`timescale 1ns/1ps

module cim_tile import fc_cfg_pkg::*, fc_types_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_w_we,
    input  w_row_t            i_w_row,
    input  logic              i_cim_we,     // Row-driver buffer write
    input  logic [ADDR_W-1:0] i_addr,
    input  plane_word_t       i_word,
    input  logic              i_cim_start,
    input  logic              i_cim_first,
    output logic              o_cim_ready,
    output acc_vec_t          o_acc
);

    logic [OUT_NEURONS-1:0][W_BITS-1:0] weights [IN_NEURONS];
    logic [IN_NEURONS-1:0]              rd_buf;      // Active rows of current plane
    logic                               busy;
    logic [CIM_CNT_W-1:0]               cnt;
    logic                               first_q;     // Evaluation is plane zero
    logic                               eval;
    logic signed [ACC_W-1:0]            col_sum [OUT_NEURONS];

    assign o_cim_ready = !busy;
    assign eval        = busy && (cnt == CIM_CNT_W'(CIM_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (i_w_we) begin
            weights[i_w_row.row] <= i_w_row.w;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cim_we) begin
            rd_buf[int'(i_addr) * BUS_WIDTH +: BUS_WIDTH] <= i_word.bits;
        end
    end

    // Busy window of CIM_CYCLES after an accepted start
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            first_q <= 1'b0;
        end else if (!busy) begin
            if (i_cim_start) begin
                busy    <= 1'b1;
                cnt     <= '0;
                first_q <= i_cim_first;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (eval) begin
                busy <= 1'b0;
            end
        end
    end

    // Column sums over the rows driven high
    always_comb begin
        for (int c = 0; c < OUT_NEURONS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < IN_NEURONS; r++) begin
                if (rd_buf[r]) begin
                    col_sum[c] = col_sum[c] + ACC_W'($signed(weights[r][c]));
                end
            end
        end
    end

    // Shift-add, MSB plane arrives first
    always_ff @(posedge clk) begin
        if (eval) begin
            for (int c = 0; c < OUT_NEURONS; c++) begin
                if (first_q) begin
                    o_acc.acc[c] <= col_sum[c];
                end else begin
                    o_acc.acc[c] <= (o_acc.acc[c] << 1) + col_sum[c];
                end
            end
        end
    end

endmodule

//--- verilog/fc_ctrl.sv
`timescale 1ns/1ps

module fc_ctrl import fc_cfg_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,         // Input buffer holds a vector
    input  logic              i_cim_ready,
    input  logic              i_func_ready,
    output logic              o_busy,
    output logic              o_cim_we,        // Row-driver write strobe
    output logic              o_cim_start,
    output logic              o_cim_first,     // Plane zero, accumulators restart
    output logic [ADDR_W-1:0] o_addr,          // Shared by tile and input buffer
    output logic              o_shift_enable,
    output logic              o_func_start,
    output logic              o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CONSUME,
        S_START,
        S_WAIT
    } state_t;

    state_t             state;
    state_t             next_state;
    logic [ADDR_W-1:0]  addr;
    logic [ADDR_W-1:0]  next_addr;
    logic [PLANE_W-1:0] plane;       // Planes already evaluated
    logic [PLANE_W-1:0] next_plane;

    assign o_addr      = addr;
    assign o_busy      = (state != S_IDLE);
    assign o_cim_first = o_cim_start && (plane == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            addr  <= '0;
            plane <= '0;
        end else begin
            state <= next_state;
            addr  <= next_addr;
            plane <= next_plane;
        end
    end

    always_comb begin
        next_state     = state;
        next_addr      = addr;
        next_plane     = plane;
        o_cim_we       = 1'b0;
        o_cim_start    = 1'b0;
        o_shift_enable = 1'b0;
        o_func_start   = 1'b0;
        o_done         = 1'b0;
        case (state)
            S_IDLE: begin
                next_addr  = '0;
                next_plane = '0;
                if (i_start && i_cim_ready) begin
                    next_state = S_CONSUME;
                end
            end
            S_CONSUME: begin
                o_cim_we = 1'b1;
                if (addr == ADDR_W'(NUM_ADDR - 1)) begin  // Last word of the plane
                    next_addr  = '0;
                    next_state = S_START;
                end else begin
                    next_addr = addr + 1'b1;
                end
            end
            S_START: begin
                // Hold start until the tile acknowledges by dropping ready
                if (i_cim_ready) begin
                    o_cim_start = 1'b1;
                end else begin
                    next_state = S_WAIT;
                end
            end
            S_WAIT: begin
                if (i_cim_ready) begin
                    if (plane == PLANE_W'(DATA_SIZE - 1)) begin  // LSB plane finished
                        o_func_start = 1'b1;
                        if (i_func_ready) begin
                            o_done     = 1'b1;
                            next_state = S_IDLE;
                        end
                    end else begin
                        o_shift_enable = 1'b1;
                        next_plane     = plane + 1'b1;
                        next_state     = S_CONSUME;
                    end
                end
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

//--- verilog/fc_ibuf.sv
`timescale 1ns/1ps

module fc_ibuf import fc_cfg_pkg::*, fc_types_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_in_valid,
    input  in_vec_t           i_in_data,
    output logic              o_in_ready,
    input  logic              i_shift_enable,  // Step to next lower plane
    input  logic              i_done,          // Vector fully consumed
    input  logic [ADDR_W-1:0] i_addr,          // Bus word select
    output logic              o_full,
    output plane_word_t       o_word
);

    in_vec_t            vec;
    logic [PLANE_W-1:0] plane;  // Current bit-plane, MSB first
    logic               accept;

    assign o_in_ready = !o_full;
    assign accept     = i_in_valid && o_in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_full <= 1'b0;
            plane  <= PLANE_W'(DATA_SIZE - 1);
        end else if (accept) begin
            o_full <= 1'b1;
            plane  <= PLANE_W'(DATA_SIZE - 1);
        end else if (i_done) begin
            o_full <= 1'b0;
        end else if (i_shift_enable) begin
            plane <= plane - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vec <= i_in_data;
        end
    end

    // Gather the current bit of each row covered by the addressed word
    always_comb begin
        for (int b = 0; b < BUS_WIDTH; b++) begin
            o_word.bits[b] = vec.act[int'(i_addr) * BUS_WIDTH + b][plane];
        end
    end

endmodule

//--- verilog/fc_types_pkg.sv
package fc_types_pkg;

    import fc_cfg_pkg::*;

    // Full activation vector from the input handshake
    typedef struct packed {
        logic [IN_NEURONS-1:0][DATA_SIZE-1:0] act;  // Unsigned activations
    } in_vec_t;

    // One row of the weight array
    typedef struct packed {
        logic [ROW_W-1:0]                  row;  // Crossbar row index
        logic [OUT_NEURONS-1:0][W_BITS-1:0] w;   // Signed weight per column
    } w_row_t;

    // One word of a bit-plane on the row-driver bus
    typedef struct packed {
        logic [BUS_WIDTH-1:0] bits;
    } plane_word_t;

    // Column accumulators, two's complement
    typedef struct packed {
        logic [OUT_NEURONS-1:0][ACC_W-1:0] acc;
    } acc_vec_t;

    // Activated and saturated layer outputs
    typedef struct packed {
        logic [OUT_NEURONS-1:0][OUT_BITS-1:0] val;
    } out_vec_t;

endpackage

//--- verilog/fc_cfg_pkg.sv
package fc_cfg_pkg;

    // Layer geometry
    localparam int DATA_SIZE   = 8;   // Activation bits, one crossbar pass per bit
    localparam int IN_NEURONS  = 16;  // Crossbar rows
    localparam int OUT_NEURONS = 8;   // Crossbar columns

    // Row-driver bus
    localparam int BUS_WIDTH = 8;
    localparam int NUM_ADDR  = IN_NEURONS / BUS_WIDTH;  // Words per bit-plane
    localparam int ADDR_W    = 1;

    // Arithmetic widths
    localparam int W_BITS   = 4;   // Signed weights
    localparam int ACC_W    = 16;  // Holds 16 rows x 8 bits x 4-bit weights
    localparam int OUT_BITS = 8;
    localparam int OUT_MAX  = (1 << OUT_BITS) - 1;

    // Timing and activation
    localparam int CIM_CYCLES = 4;  // Busy cycles per crossbar evaluation
    localparam int OUT_SHIFT  = 4;

    // Derived counter widths
    localparam int PLANE_W   = $clog2(DATA_SIZE);
    localparam int ROW_W     = $clog2(IN_NEURONS);
    localparam int CIM_CNT_W = $clog2(CIM_CYCLES);

endpackage
